//--- dual_alu_exec.sv
`timescale 1ns/1ps

module dual_alu_exec
    import pipe_types_pkg::*;
    import uop_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      lat_valid,
    input  uop_t      lat_uop0,
    input  uop_t      lat_uop1,
    input  reg_addr_t lat_rj0,
    input  reg_addr_t lat_rj1,
    input  reg_addr_t lat_rk0,
    input  reg_addr_t lat_rk1,
    input  reg_addr_t lat_rd0,
    input  reg_addr_t lat_rd1,
    input  imm_t      lat_imm0,
    input  imm_t      lat_imm1,
    input  word_t     lat_rj_data0,
    input  word_t     lat_rj_data1,
    input  word_t     lat_rk_data0,
    input  word_t     lat_rk_data1,
    output logic      ex_allowin,
    output logic      fwd_we0,
    output logic      fwd_we1,
    output reg_addr_t fwd_rd0,
    output reg_addr_t fwd_rd1,
    output word_t     fwd_data0,
    output word_t     fwd_data1,
    output reg_addr_t load_wait_rd,
    output logic      mem_req,
    output word_t     mem_addr,
    input  logic      mem_rvalid,
    input  word_t     mem_rdata,
    output logic      wb_we0,
    output logic      wb_we1,
    output logic      wb_we2,
    output reg_addr_t wb_rd0,
    output reg_addr_t wb_rd1,
    output reg_addr_t wb_rd2,
    output word_t     wb_data0,
    output word_t     wb_data1,
    output word_t     wb_data2
);

    ex_state_t state;
    reg_addr_t ld_rd;
    logic      consume;
    logic      ld_issue;

    // a source naming r0 is zero whatever data was captured
    function automatic word_t src(input reg_addr_t addr, input word_t data);
        return (addr == '0) ? '0 : data;
    endfunction

    // a load yields its address here
    function automatic word_t alu(input uop_t uop, input word_t a, input word_t b,
                                  input imm_t imm);
        case (uop)
            UOP_ADD:  return a + b;
            UOP_SUB:  return a - b;
            UOP_AND:  return a & b;
            UOP_OR:   return a | b;
            UOP_XOR:  return a ^ b;
            UOP_SLTU: return (a < b) ? word_t'(1) : '0;
            UOP_ADDI: return a + imm;
            UOP_LD:   return a + imm;
            default:  return '0;
        endcase
    endfunction

    always_comb begin
        fwd_data0 = alu(lat_uop0, src(lat_rj0, lat_rj_data0), src(lat_rk0, lat_rk_data0),
                        lat_imm0);
        fwd_data1 = alu(lat_uop1, src(lat_rj1, lat_rj_data1), src(lat_rk1, lat_rk_data1),
                        lat_imm1);
        fwd_rd0   = lat_rd0;
        fwd_rd1   = lat_rd1;
        fwd_we0   = lat_valid && lat_rd0 != '0 && lat_uop0 != UOP_LD;
        fwd_we1   = lat_valid && lat_rd1 != '0 && lat_uop1 != UOP_LD;
    end

    assign ex_allowin   = (state == EX_IDLE);
    assign consume      = lat_valid && ex_allowin;
    assign ld_issue     = consume && lat_uop0 == UOP_LD;
    assign load_wait_rd = (state == EX_WAIT) ? ld_rd : '0;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= EX_IDLE;
            mem_req <= 1'b0;
            wb_we0  <= 1'b0;
            wb_we1  <= 1'b0;
            wb_we2  <= 1'b0;
        end else begin
            mem_req <= ld_issue;
            wb_we0  <= consume && fwd_we0;
            wb_we1  <= consume && fwd_we1;
            wb_we2  <= state == EX_WAIT && mem_rvalid && ld_rd != '0;
            case (state)
                EX_IDLE: if (ld_issue) state <= EX_WAIT;
                EX_WAIT: if (mem_rvalid) state <= EX_IDLE;
                default: state <= EX_IDLE;
            endcase
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        wb_rd0   <= lat_rd0;
        wb_rd1   <= lat_rd1;
        wb_data0 <= fwd_data0;
        wb_data1 <= fwd_data1;
        wb_rd2   <= ld_rd;
        wb_data2 <= mem_rdata;
        if (ld_issue) begin
            ld_rd    <= lat_rd0;
            mem_addr <= fwd_data0;
        end
    end

endmodule

//--- filelist.f
pipe_types_pkg.sv
uop_pkg.sv
regfile.sv
operand_read.sv
reg_ex_latch.sv
dual_alu_exec.sv
rr_ex_top.sv
tb_rr_ex.sv

//--- operand_read.sv
`timescale 1ns/1ps

module operand_read
    import pipe_types_pkg::*;
    import uop_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      in_valid,
    input  uop_t      uop0,
    input  uop_t      uop1,
    input  reg_addr_t rj0,
    input  reg_addr_t rj1,
    input  reg_addr_t rk0,
    input  reg_addr_t rk1,
    input  logic      latch_allowin,
    input  logic      lat_valid,
    input  uop_t      lat_uop0,
    input  reg_addr_t lat_rd0,
    input  reg_addr_t load_wait_rd,
    input  logic      fwd_we0,
    input  logic      fwd_we1,
    input  reg_addr_t fwd_rd0,
    input  reg_addr_t fwd_rd1,
    input  word_t     fwd_data0,
    input  word_t     fwd_data1,
    input  logic      wb_we0,
    input  logic      wb_we1,
    input  logic      wb_we2,
    input  reg_addr_t wb_rd0,
    input  reg_addr_t wb_rd1,
    input  reg_addr_t wb_rd2,
    input  word_t     wb_data0,
    input  word_t     wb_data1,
    input  word_t     wb_data2,
    output logic      in_ready,
    output logic      rr_valid,
    output word_t     rj_data0,
    output word_t     rj_data1,
    output word_t     rk_data0,
    output word_t     rk_data1
);

    word_t     rf_rj0;
    word_t     rf_rj1;
    word_t     rf_rk0;
    word_t     rf_rk1;
    reg_addr_t lat_ld_rd;
    logic      hazard;

    regfile u_regfile (
        .clk    (clk),
        .aresetn(aresetn),
        .we0    (wb_we0),
        .waddr0 (wb_rd0),
        .wdata0 (wb_data0),
        .we1    (wb_we1),
        .waddr1 (wb_rd1),
        .wdata1 (wb_data1),
        .we2    (wb_we2),
        .waddr2 (wb_rd2),
        .wdata2 (wb_data2),
        .raddr0 (rj0),
        .raddr1 (rk0),
        .raddr2 (rj1),
        .raddr3 (rk1),
        .rdata0 (rf_rj0),
        .rdata1 (rf_rk0),
        .rdata2 (rf_rj1),
        .rdata3 (rf_rk1)
    );

    // rk is only a source for the register-register ops
    function automatic logic uses_rk(input uop_t uop);
        return uop inside {UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR, UOP_SLTU};
    endfunction

    function automatic logic uses_rj(input uop_t uop);
        return uses_rk(uop) || uop == UOP_ADDI || uop == UOP_LD;
    endfunction

    // does any live source of the incoming pair name r
    function automatic logic pair_reads(input reg_addr_t r);
        logic hit;
        hit = 1'b0;
        if (r != '0) begin
            hit = (uses_rj(uop0) && rj0 == r) || (uses_rk(uop0) && rk0 == r) ||
                  (uses_rj(uop1) && rj1 == r) || (uses_rk(uop1) && rk1 == r);
        end
        return hit;
    endfunction

    // lane 1 of the latch pair is younger, so it wins over lane 0
    function automatic word_t fwd_sel(input reg_addr_t addr, input word_t rf_data);
        word_t data;
        data = rf_data;
        if (fwd_we0 && fwd_rd0 == addr) data = fwd_data0;
        if (fwd_we1 && fwd_rd1 == addr) data = fwd_data1;
        return data;
    endfunction

    always_comb begin
        rj_data0 = fwd_sel(rj0, rf_rj0);
        rk_data0 = fwd_sel(rk0, rf_rk0);
        rj_data1 = fwd_sel(rj1, rf_rj1);
        rk_data1 = fwd_sel(rk1, rf_rk1);
    end

    // load in the latch or still waiting on memory has no forward value yet
    always_comb begin
        lat_ld_rd = (lat_valid && lat_uop0 == UOP_LD) ? lat_rd0 : '0;
        hazard    = pair_reads(lat_ld_rd) || pair_reads(load_wait_rd);
        in_ready  = latch_allowin && !hazard;
        rr_valid  = in_valid && in_ready;
    end

endmodule

//--- pipe_types_pkg.sv
package pipe_types_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // architectural register count, entry 0 hardwired to zero
    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // one data word on any datapath port
    typedef logic [WORD_W-1:0] word_t;

    // register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // immediate, already sign extended by decode
    typedef logic [WORD_W-1:0] imm_t;

endpackage

//--- reg_ex_latch.sv
`timescale 1ns/1ps

module reg_ex_latch
    import pipe_types_pkg::*;
    import uop_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      rr_valid,
    input  logic      ex_allowin,
    input  uop_t      uop0,
    input  uop_t      uop1,
    input  reg_addr_t rj0,
    input  reg_addr_t rj1,
    input  reg_addr_t rk0,
    input  reg_addr_t rk1,
    input  reg_addr_t rd0,
    input  reg_addr_t rd1,
    input  imm_t      imm0,
    input  imm_t      imm1,
    input  word_t     rj_data0,
    input  word_t     rj_data1,
    input  word_t     rk_data0,
    input  word_t     rk_data1,
    output logic      latch_allowin,
    output logic      lat_valid,
    output uop_t      lat_uop0,
    output uop_t      lat_uop1,
    output reg_addr_t lat_rj0,
    output reg_addr_t lat_rj1,
    output reg_addr_t lat_rk0,
    output reg_addr_t lat_rk1,
    output reg_addr_t lat_rd0,
    output reg_addr_t lat_rd1,
    output imm_t      lat_imm0,
    output imm_t      lat_imm1,
    output word_t     lat_rj_data0,
    output word_t     lat_rj_data1,
    output word_t     lat_rk_data0,
    output word_t     lat_rk_data1
);

    // room for a new pair when empty or when execute takes the current one
    assign latch_allowin = !lat_valid || ex_allowin;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            lat_valid <= 1'b0;
        end else if (rr_valid) begin
            lat_valid <= 1'b1;
        end else if (ex_allowin) begin
            // drained with nothing behind it, becomes a bubble
            lat_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            lat_uop0     <= '0;
            lat_uop1     <= '0;
            lat_rj0      <= '0;
            lat_rj1      <= '0;
            lat_rk0      <= '0;
            lat_rk1      <= '0;
            lat_rd0      <= '0;
            lat_rd1      <= '0;
            lat_imm0     <= '0;
            lat_imm1     <= '0;
            lat_rj_data0 <= '0;
            lat_rj_data1 <= '0;
            lat_rk_data0 <= '0;
            lat_rk_data1 <= '0;
        end else if (rr_valid) begin
            lat_uop0     <= uop0;
            lat_uop1     <= uop1;
            lat_rj0      <= rj0;
            lat_rj1      <= rj1;
            lat_rk0      <= rk0;
            lat_rk1      <= rk1;
            lat_rd0      <= rd0;
            lat_rd1      <= rd1;
            lat_imm0     <= imm0;
            lat_imm1     <= imm1;
            lat_rj_data0 <= rj_data0;
            lat_rj_data1 <= rj_data1;
            lat_rk_data0 <= rk_data0;
            lat_rk_data1 <= rk_data1;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile
    import pipe_types_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      we0,
    input  reg_addr_t waddr0,
    input  word_t     wdata0,
    input  logic      we1,
    input  reg_addr_t waddr1,
    input  word_t     wdata1,
    input  logic      we2,
    input  reg_addr_t waddr2,
    input  word_t     wdata2,
    input  reg_addr_t raddr0,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t raddr3,
    output word_t     rdata0,
    output word_t     rdata1,
    output word_t     rdata2,
    output word_t     rdata3
);

    word_t regs [NUM_REGS];

    // writers never raise we with address 0, so entry 0 stays zero
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0) regs[waddr0] <= wdata0;
            if (we1) regs[waddr1] <= wdata1;
            if (we2) regs[waddr2] <= wdata2;
        end
    end

    // write-first, the later port wins when two writes hit one address
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        data = regs[addr];
        if (we0 && waddr0 == addr) data = wdata0;
        if (we1 && waddr1 == addr) data = wdata1;
        if (we2 && waddr2 == addr) data = wdata2;
        return data;
    endfunction

    always_comb begin
        rdata0 = read_port(raddr0);
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
        rdata3 = read_port(raddr3);
    end

endmodule

//--- rr_ex_top.sv
`timescale 1ns/1ps

module rr_ex_top
    import pipe_types_pkg::*;
    import uop_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      in_valid,
    input  uop_t      uop0,
    input  uop_t      uop1,
    input  reg_addr_t rj0,
    input  reg_addr_t rj1,
    input  reg_addr_t rk0,
    input  reg_addr_t rk1,
    input  reg_addr_t rd0,
    input  reg_addr_t rd1,
    input  imm_t      imm0,
    input  imm_t      imm1,
    input  logic      mem_rvalid,
    input  word_t     mem_rdata,
    output logic      in_ready,
    output logic      mem_req,
    output word_t     mem_addr,
    output logic      wb_we0,
    output logic      wb_we1,
    output logic      wb_we2,
    output reg_addr_t wb_rd0,
    output reg_addr_t wb_rd1,
    output reg_addr_t wb_rd2,
    output word_t     wb_data0,
    output word_t     wb_data1,
    output word_t     wb_data2
);

    // register read to latch
    logic      rr_valid;
    word_t     rj_data0, rj_data1, rk_data0, rk_data1;

    // latch to execute
    logic      latch_allowin;
    logic      lat_valid;
    uop_t      lat_uop0, lat_uop1;
    reg_addr_t lat_rj0, lat_rj1, lat_rk0, lat_rk1, lat_rd0, lat_rd1;
    imm_t      lat_imm0, lat_imm1;
    word_t     lat_rj_data0, lat_rj_data1, lat_rk_data0, lat_rk_data1;

    // execute back to register read
    logic      ex_allowin;
    logic      fwd_we0, fwd_we1;
    reg_addr_t fwd_rd0, fwd_rd1;
    word_t     fwd_data0, fwd_data1;
    reg_addr_t load_wait_rd;

    // port names match across the slice
    operand_read u_operand_read (.*);

    reg_ex_latch u_reg_ex_latch (.*);

    dual_alu_exec u_dual_alu_exec (.*);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_rr_ex -f filelist.f

output=$(./obj_dir/Vtb_rr_ex || true)
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

//--- tb_rr_ex.sv
`timescale 1ns/1ps

module tb_rr_ex
    import pipe_types_pkg::*;
    import uop_pkg::*;
();

    localparam int NUM_PAIRS       = 400;
    // first pairs draw from all 32 registers, the rest from r0..r7
    localparam int INDEP_PAIRS     = 100;
    localparam int WATCHDOG_CYCLES = NUM_PAIRS * 40 + 500;

    logic      clk = 1'b0;
    logic      aresetn;
    logic      in_valid;
    uop_t      uop0, uop1;
    reg_addr_t rj0, rj1, rk0, rk1, rd0, rd1;
    imm_t      imm0, imm1;
    logic      mem_rvalid = 1'b0;
    word_t     mem_rdata = '0;
    logic      in_ready;
    logic      mem_req;
    word_t     mem_addr;
    logic      wb_we0, wb_we1, wb_we2;
    reg_addr_t wb_rd0, wb_rd1, wb_rd2;
    word_t     wb_data0, wb_data1, wb_data2;

    integer seed;
    int     stall_cycles = 0;

    // memory model state
    word_t mem_words [16];
    int    lat_tab [64];
    int    mem_wait = 0;
    int    load_cnt = 0;
    word_t pend_addr;

    // reference model state, queue entries are {rd, data}
    word_t       model_regs [NUM_REGS];
    logic [36:0] exp_q0 [$];
    logic [36:0] exp_q1 [$];
    logic [36:0] exp_q2 [$];
    word_t       exp_addr_q [$];

    rr_ex_top DUT (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // codes above 8 fold back onto the defined ops, 8 stays undefined
    function automatic uop_t pick_uop(input logic [3:0] c);
        return (c > 4'h8) ? {1'b0, c[2:0]} : c;
    endfunction

    function automatic reg_addr_t pick_reg(input int n);
        logic [31:0] r;
        r = next_rand();
        return (n < INDEP_PAIRS) ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    function automatic word_t model_alu(input uop_t uop, input word_t a, input word_t b,
                                        input imm_t imm);
        word_t res;
        res = '0;
        if (uop == UOP_ADD) res = a + b;
        else if (uop == UOP_SUB) res = a - b;
        else if (uop == UOP_AND) res = a & b;
        else if (uop == UOP_OR) res = a | b;
        else if (uop == UOP_XOR) res = a ^ b;
        else if (uop == UOP_SLTU && a < b) res = 32'd1;
        else if (uop == UOP_ADDI) res = a + imm;
        return res;
    endfunction

    // random pair, then patched so lane 1 never touches lane 0's rd
    task automatic make_pair(input int n);
        logic [31:0] r;
        r = next_rand();
        uop0 = pick_uop(r[3:0]);
        uop1 = pick_uop(r[7:4]);
        if (uop1 == UOP_LD) uop1 = UOP_ADDI;
        rj0 = pick_reg(n);
        rk0 = pick_reg(n);
        rd0 = pick_reg(n);
        rj1 = pick_reg(n);
        rk1 = pick_reg(n);
        rd1 = pick_reg(n);
        imm0 = next_rand();
        imm1 = next_rand();
        if (rd0 != '0) begin
            if (rj1 == rd0) rj1 = rd0 ^ 5'd1;
            if (rk1 == rd0) rk1 = rd0 ^ 5'd1;
            if (rd1 == rd0) rd1 = rd0 ^ 5'd1;
        end
    endtask

    // lane order, lane 0 first
    task automatic model_execute();
        word_t a0, b0, a1, b1, res0, res1, addr;
        a0 = model_regs[rj0];
        b0 = model_regs[rk0];
        if (uop0 == UOP_LD) begin
            addr = a0 + imm0;
            exp_addr_q.push_back(addr);
            res0 = mem_words[addr[5:2]];
            if (rd0 != '0) exp_q2.push_back({rd0, res0});
        end else begin
            res0 = model_alu(uop0, a0, b0, imm0);
            if (rd0 != '0) exp_q0.push_back({rd0, res0});
        end
        if (rd0 != '0) model_regs[rd0] = res0;
        a1 = model_regs[rj1];
        b1 = model_regs[rk1];
        res1 = model_alu(uop1, a1, b1, imm1);
        if (rd1 != '0) begin
            exp_q1.push_back({rd1, res1});
            model_regs[rd1] = res1;
        end
    endtask

    // holds the pair until in_ready was high before a rising edge
    task automatic issue_pair(input int n);
        logic ready_seen;
        @(negedge clk);
        make_pair(n);
        in_valid = 1'b1;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            #1;
            ready_seen = in_ready;
            @(posedge clk);
            if (!ready_seen) begin
                stall_cycles++;
                @(negedge clk);
            end
        end
        model_execute();
    endtask

    task automatic check_wb(input int port, input reg_addr_t rd, input word_t data);
        logic [36:0] entry;
        int          depth;
        case (port)
            0:       depth = exp_q0.size();
            1:       depth = exp_q1.size();
            default: depth = exp_q2.size();
        endcase
        if (depth == 0) begin
            abort_run($sformatf("writeback on port %0d with no result expected", port));
        end else begin
            case (port)
                0:       entry = exp_q0.pop_front();
                1:       entry = exp_q1.pop_front();
                default: entry = exp_q2.pop_front();
            endcase
            check_value($sformatf("wb_rd%0d", port), 32'(rd), 32'(entry[36:32]));
            check_value($sformatf("wb_data%0d", port), data, entry[31:0]);
        end
    endtask

    // registered outputs, stable at the falling edge
    always @(negedge clk) begin
        if (aresetn) begin
            if (wb_we0) check_wb(0, wb_rd0, wb_data0);
            if (wb_we1) check_wb(1, wb_rd1, wb_data1);
            if (wb_we2) check_wb(2, wb_rd2, wb_data2);
        end
    end

    // one load at a time, answered 1 to 4 cycles after the request
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        if (mem_wait != 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = mem_words[pend_addr[5:2]];
            end
        end
        if (aresetn && mem_req) begin
            if (mem_wait != 0) begin
                abort_run("second memory request while a load was outstanding");
            end else if (exp_addr_q.size() == 0) begin
                abort_run("memory request with no load accepted");
            end else begin
                check_value("mem_addr", mem_addr, exp_addr_q.pop_front());
                pend_addr = mem_addr;
                mem_wait  = lat_tab[load_cnt % 64];
                load_cnt++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all pairs drained");
    end

    initial begin
        logic [31:0] r;
        seed     = 32'hc1e2_0c5c;
        aresetn  = 1'b0;
        in_valid = 1'b0;
        uop0     = '0;
        uop1     = '0;
        rj0      = '0;
        rj1      = '0;
        rk0      = '0;
        rk1      = '0;
        rd0      = '0;
        rd1      = '0;
        imm0     = '0;
        imm1     = '0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        for (int i = 0; i < 16; i++) mem_words[i] = next_rand();
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            lat_tab[i] = int'(r[1:0]) + 1;
        end
        repeat (4) @(negedge clk);
        aresetn = 1'b1;
        repeat (3) @(negedge clk);
        check_value("in_ready", 32'(in_ready), 32'd1);
        for (int n = 0; n < NUM_PAIRS; n++) begin
            // an idle cycle now and then spaces pairs out for the regfile bypass
            r = next_rand();
            if (r[1:0] == 2'b00) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            issue_pair(n);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q0.size() + exp_q1.size() + exp_q2.size() + exp_addr_q.size() != 0) begin
            @(negedge clk);
        end
        // quiet cycles to catch a stray writeback or request
        repeat (10) @(negedge clk);
        if (stall_cycles == 0) begin
            abort_run("in_ready never dropped while a pair was offered");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- uop_pkg.sv
package uop_pkg;

    localparam int UOP_W = 4;

    typedef logic [UOP_W-1:0] uop_t;

    // register-register ops
    localparam uop_t UOP_ADD  = 4'h0;
    localparam uop_t UOP_SUB  = 4'h1;
    localparam uop_t UOP_AND  = 4'h2;
    localparam uop_t UOP_OR   = 4'h3;
    localparam uop_t UOP_XOR  = 4'h4;
    // unsigned compare, result is 0 or 1
    localparam uop_t UOP_SLTU = 4'h5;

    // register-immediate ops
    localparam uop_t UOP_ADDI = 4'h6;
    // word load at rj + imm, lane 0 only
    localparam uop_t UOP_LD   = 4'h7;

    // execute stage FSM
    typedef enum logic [0:0] {
        EX_IDLE,
        EX_WAIT
    } ex_state_t;

endpackage
